// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = pcie_tx_tb
RTL_TOP   = pcie_tx
FILELIST  = pcie_tx.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: logic/beat_counter.sv
`default_nettype none

module beat_counter #(
   parameter int WR_BEATS = 16
) (
   input  logic clock,
   input  logic reset,
   input  logic count_clear,
   input  logic count_en,
   output logic data_done
);

   localparam int CW = $clog2(WR_BEATS + 1);

   logic [CW-1:0] count_q; // data requests issued so far

   always_ff @(posedge clock)
   begin
      if (reset || count_clear)
         count_q <= '0;
      else if (count_en)
         count_q <= count_q + 1'b1;
   end

   // high once the final request has gone out, which also stops count_en
   assign data_done = (count_q == CW'(WR_BEATS));

endmodule

`default_nettype wire

// File: logic/payload_aligner.sv
`default_nettype none

module payload_aligner import pcie_tx_pkg::*; (
   input  logic        clock,
   input  logic        reset,
   input  beat_sel_t   sel,
   input  logic [63:0] wr_addr,
   input  logic [63:0] wr_data,
   input  logic [63:0] rc_data,
   output tx_beat_t    data_beat
);

   logic [63:0] prev_q;     // write word fetched on the previous advance
   logic [31:0] cur_lo_sw;
   logic [31:0] prev_lo_sw;
   logic [31:0] prev_hi_sw;

   always_ff @(posedge clock)
   begin
      if (reset)
         prev_q <= '0;
      else if (sel.advance && sel.kind == mem_write)
         prev_q <= wr_data;
   end

   assign cur_lo_sw  = es_dw(wr_data[31:0]);
   assign prev_lo_sw = es_dw(prev_q[31:0]);
   assign prev_hi_sw = es_dw(prev_q[63:32]);

   always_comb
   begin
      data_beat = '0;
      case (sel.state)
         cpl_data1:
         begin
            data_beat.data   = {32'h0, es_dw(rc_data[63:32])};
            data_beat.one_dw = 1'b1;
            data_beat.last   = 1'b1;
         end
         wr_first:
         begin
            // 3dw header puts the first payload dword next to the address
            if (sel.addr_32)
               data_beat.data = {cur_lo_sw, wr_addr[31:0]};
            else
               data_beat.data = {wr_addr[31:0], wr_addr[63:32]};
         end
         wr_body:
         begin
            if (sel.addr_32)
               data_beat.data = {cur_lo_sw, prev_hi_sw}; // shifted by one dword
            else
               data_beat.data = {prev_hi_sw, prev_lo_sw};
         end
         wr_tail:
         begin
            data_beat.data   = sel.addr_32 ? {32'h0, prev_hi_sw} : {prev_hi_sw, prev_lo_sw};
            data_beat.one_dw = sel.addr_32;   // odd dword count left over
            data_beat.last   = 1'b1;
         end
         default:
            data_beat = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/pcie_tx.sv
`default_nettype none

module pcie_tx import pcie_tx_pkg::*; #(
   parameter int WR_BEATS  = 16,
   parameter int RD_LEN_DW = 128
) (
   input  logic        clock,
   input  logic        reset,
   input  logic [15:0] pcie_id,
   input  logic        rc_done,
   input  logic [31:0] rc_dw2,
   input  logic [63:0] rc_data,
   input  logic        rr_valid,
   input  logic [63:0] rr_addr,
   input  logic [7:0]  rr_tag,
   output logic        rr_ready,
   input  logic        wr_valid,
   input  logic [63:0] wr_addr,
   input  logic [63:0] wr_data,
   output logic        wr_ready, // one pulse per wanted wr_data word
   input  logic        tx_tready,
   output logic [63:0] tx_tdata,
   output logic        tx_1dw,
   output logic        tx_tlast,
   output logic        tx_tvalid
);

   logic      advance;
   logic      data_done;
   logic      count_en;
   logic      count_clear;
   logic      use_hdr;
   beat_sel_t sel;
   tx_beat_t  hdr_beat;
   tx_beat_t  data_beat;
   tx_beat_t  next_beat;

   // output register free or being drained
   assign advance = tx_tready || !tx_tvalid;

   tx_sequencer #(.WR_BEATS(WR_BEATS)) i_tx_sequencer (
      .clock       (clock),
      .reset       (reset),
      .advance     (advance),
      .rc_done     (rc_done),
      .rr_valid    (rr_valid),
      .wr_valid    (wr_valid),
      .rr_addr_32  (rr_addr[63:32] == 32'h0),
      .wr_addr_32  (wr_addr[63:32] == 32'h0),
      .data_done   (data_done),
      .sel         (sel),
      .rr_ready    (rr_ready),
      .wr_ready    (wr_ready),
      .count_en    (count_en),
      .count_clear (count_clear)
   );

   beat_counter #(.WR_BEATS(WR_BEATS)) i_beat_counter (
      .clock       (clock),
      .reset       (reset),
      .count_clear (count_clear),
      .count_en    (count_en),
      .data_done   (data_done)
   );

   tlp_header_gen #(.WR_BEATS(WR_BEATS), .RD_LEN_DW(RD_LEN_DW)) i_tlp_header_gen (
      .sel      (sel),
      .pcie_id  (pcie_id),
      .rc_dw2   (rc_dw2),
      .rc_data  (rc_data),
      .rr_addr  (rr_addr),
      .rr_tag   (rr_tag),
      .wr_addr  (wr_addr),
      .hdr_beat (hdr_beat)
   );

   payload_aligner i_payload_aligner (
      .clock     (clock),
      .reset     (reset),
      .sel       (sel),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rc_data   (rc_data),
      .data_beat (data_beat)
   );

   always_comb
   begin
      case (sel.state)
         cpl_hdr, cpl_data0, rd_hdr, rd_addr, wr_hdr: use_hdr = 1'b1;
         default:                                     use_hdr = 1'b0;
      endcase
   end

   assign next_beat = use_hdr ? hdr_beat : data_beat;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         tx_tvalid <= 1'b0;
         tx_tlast  <= 1'b0;
      end
      else if (advance)
      begin
         tx_tvalid <= (sel.state != idle);
         tx_tlast  <= next_beat.last;
      end
   end

   always_ff @(posedge clock)
   begin
      if (advance)
      begin
         tx_tdata <= next_beat.data;
         tx_1dw   <= next_beat.one_dw;
      end
   end

endmodule

`default_nettype wire

// File: logic/pcie_tx_pkg.sv
`default_nettype none

package pcie_tx_pkg;

   // sequencer phase, one value per output beat slot
   typedef enum logic [3:0] {
      idle,
      cpl_hdr,
      cpl_data0,
      cpl_data1,
      rd_hdr,
      rd_addr,
      wr_hdr,
      wr_first,
      wr_body,
      wr_tail
   } tx_state_e;

   // packet opcode
   typedef enum logic [1:0] {
      completion,
      mem_read,
      mem_write
   } tlp_kind_e;

   // one beat toward the core
   typedef struct packed {
      logic [63:0] data;
      logic        one_dw; // only data[31:0] valid
      logic        last;
   } tx_beat_t;

   // what the sequencer tells the data path
   typedef struct packed {
      tlp_kind_e kind;
      tx_state_e state;
      logic      addr_32;  // 3 dword header
      logic      advance;  // output register takes a beat this cycle
   } beat_sel_t;

   // fmt/type byte of header dword 0
   localparam logic [7:0] CPL_FMT_TYPE = 8'h4a; // cpld, 3dw
   localparam logic [7:0] MRD_FMT      = 8'h00;
   localparam logic [7:0] MWR_FMT      = 8'h40;
   localparam logic [7:0] FMT_4DW      = 8'h20; // or'd in for 64-bit address

   localparam logic [7:0]  BE_ALL     = 8'hff;  // first and last byte enables
   localparam logic [9:0]  CPL_LEN_DW = 10'd2;
   localparam logic [11:0] CPL_BYTES  = 12'd8;

   // byte reversal into pcie dword order
   function automatic logic [31:0] es_dw(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

endpackage

`default_nettype wire

// File: logic/tlp_header_gen.sv
`default_nettype none

module tlp_header_gen import pcie_tx_pkg::*; #(
   parameter int WR_BEATS  = 16,
   parameter int RD_LEN_DW = 128
) (
   input  beat_sel_t   sel,
   input  logic [15:0] pcie_id,
   input  logic [31:0] rc_dw2,
   input  logic [63:0] rc_data,
   input  logic [63:0] rr_addr,
   input  logic [7:0]  rr_tag,
   input  logic [63:0] wr_addr,
   output tx_beat_t    hdr_beat
);

   localparam logic [9:0] RD_LEN = 10'(RD_LEN_DW);
   localparam logic [9:0] WR_LEN = 10'(2 * WR_BEATS); // two dwords per data word

   logic [7:0]  fmt_4dw;
   logic [63:0] rd_addr_beat;

   // header dword 0 with tc, attr and td all zero
   function automatic logic [31:0] dw0(input logic [7:0] fmt_type, input logic [9:0] len);
      return {fmt_type, 14'h0, len};
   endfunction

   assign fmt_4dw = sel.addr_32 ? 8'h00 : FMT_4DW;

   // 64-bit address goes out upper dword first
   assign rd_addr_beat = sel.addr_32 ? {32'h0, rr_addr[31:0]}
                                     : {rr_addr[31:0], rr_addr[63:32]};

   always_comb
   begin
      hdr_beat = '0;
      case (sel.state)
         cpl_hdr:
            hdr_beat.data = {pcie_id, 4'h0, CPL_BYTES, dw0(CPL_FMT_TYPE, CPL_LEN_DW)};
         cpl_data0:
            hdr_beat.data = {es_dw(rc_data[31:0]), rc_dw2}; // dw2 plus first payload dword
         rd_hdr:
            hdr_beat.data = {pcie_id, rr_tag, BE_ALL, dw0(MRD_FMT | fmt_4dw, RD_LEN)};
         rd_addr:
         begin
            hdr_beat.data   = rd_addr_beat;
            hdr_beat.one_dw = sel.addr_32;
            hdr_beat.last   = 1'b1;
         end
         wr_hdr:
            hdr_beat.data = {pcie_id, 8'h00, BE_ALL, dw0(MWR_FMT | fmt_4dw, WR_LEN)};
         default:
            hdr_beat = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/tx_sequencer.sv
`default_nettype none

module tx_sequencer import pcie_tx_pkg::*; #(
   parameter int WR_BEATS = 16
) (
   input  logic      clock,
   input  logic      reset,
   input  logic      advance,
   input  logic      rc_done,
   input  logic      rr_valid,
   input  logic      wr_valid,
   input  logic      rr_addr_32,
   input  logic      wr_addr_32,
   input  logic      data_done,
   output beat_sel_t sel,
   output logic      rr_ready,
   output logic      wr_ready,
   output logic      count_en,
   output logic      count_clear
);

   tx_state_e state_q;
   tx_state_e state_nx;
   tx_state_e next_pkt; // first beat of the packet picked at a boundary
   logic      rc_pend_q;
   logic      wr_32_q;
   logic      wr_fetch;

   function automatic logic is_last_beat(input tx_state_e s);
      return (s == cpl_data1) || (s == rd_addr) || (s == wr_tail);
   endfunction

   function automatic tlp_kind_e kind_of(input tx_state_e s);
      case (s)
         rd_hdr, rd_addr:                    return mem_read;
         wr_hdr, wr_first, wr_body, wr_tail: return mem_write;
         default:                            return completion;
      endcase
   endfunction

   // priority pick, a request that just ended is not restarted on the same edge
   always_comb
   begin
      if (rc_pend_q && state_q != cpl_data1)
         next_pkt = cpl_hdr;
      else if (rr_valid && state_q != rd_addr)
         next_pkt = rd_hdr;
      else if (wr_valid && state_q != wr_tail)
         next_pkt = wr_hdr;
      else
         next_pkt = idle;
   end

   always_comb
   begin
      if (state_q == idle || is_last_beat(state_q))
         state_nx = next_pkt;
      else
      begin
         case (state_q)
            cpl_hdr:   state_nx = cpl_data0;
            cpl_data0: state_nx = cpl_data1;
            rd_hdr:    state_nx = rd_addr;
            wr_hdr:    state_nx = wr_first;
            wr_first:  state_nx = (WR_BEATS == 1) ? wr_tail : wr_body; // no body for one word
            wr_body:   state_nx = data_done ? wr_tail : wr_body;
            default:   state_nx = idle;
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state_q   <= idle;
         rc_pend_q <= 1'b0;
         wr_32_q   <= 1'b1;
      end
      else
      begin
         if (advance)
            state_q <= state_nx;
         if (rc_done) // a new strobe wins over the clear
            rc_pend_q <= 1'b1;
         else if (advance && state_q == cpl_data1)
            rc_pend_q <= 1'b0;
         if (state_q == wr_hdr)
            wr_32_q <= wr_addr_32; // hold width for the rest of the write
      end
   end

   assign wr_fetch = (state_q == wr_hdr) || (state_q == wr_first) || (state_q == wr_body);

   assign rr_ready    = advance && (state_q == rd_addr);
   assign wr_ready    = advance && wr_fetch && !data_done;
   assign count_en    = wr_ready;
   assign count_clear = advance && (state_nx == wr_hdr); // entering a write header

   always_comb
   begin
      sel.kind    = kind_of(state_q);
      sel.state   = state_q;
      sel.advance = advance;
      case (state_q)
         rd_hdr, rd_addr:            sel.addr_32 = rr_addr_32;
         wr_hdr:                     sel.addr_32 = wr_addr_32;
         wr_first, wr_body, wr_tail: sel.addr_32 = wr_32_q;
         default:                    sel.addr_32 = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: pcie_tx.f
+incdir+tests
logic/pcie_tx_pkg.sv
logic/tx_sequencer.sv
logic/beat_counter.sv
logic/tlp_header_gen.sv
logic/payload_aligner.sv
logic/pcie_tx.sv
tests/pcie_tx_tb.sv

// File: tests/tlp_model.svh
`ifndef TLP_MODEL_SVH
`define TLP_MODEL_SVH

// byte order of a dword as it goes on the link
function automatic logic [31:0] swap32(input logic [31:0] x);
   logic [31:0] r;
   for (int b = 0; b < 4; b++)
      r[8*b +: 8] = x[8*(3-b) +: 8];
   return r;
endfunction

function automatic void push_beat(input logic [63:0] d, input logic one, input logic lst);
   tx_beat_t b;
   b.data   = d;
   b.one_dw = one;
   b.last   = lst;
   exp_q.push_back(b);
endfunction

function automatic void model_cpl(input logic [15:0] id, input logic [31:0] dw2,
                                  input logic [63:0] d);
   push_beat({id, 4'h0, 12'd8, 8'h4a, 14'h0, 10'd2}, 1'b0, 1'b0);
   push_beat({swap32(d[31:0]), dw2}, 1'b0, 1'b0);
   push_beat({32'h0, swap32(d[63:32])}, 1'b1, 1'b1);
endfunction

function automatic void model_read(input logic [15:0] id, input logic [63:0] a,
                                   input logic [7:0] tag);
   logic a32;
   a32 = (a[63:32] == 32'h0);
   push_beat({id, tag, 8'hff, (a32 ? 8'h00 : 8'h20), 14'h0, 10'(RD_LEN_DW)}, 1'b0, 1'b0);
   if (a32)
      push_beat({32'h0, a[31:0]}, 1'b1, 1'b1);
   else
      push_beat({a[31:0], a[63:32]}, 1'b0, 1'b1);
endfunction

// data words come from wr_words in fetch order
function automatic void model_write(input logic [15:0] id, input logic [63:0] a);
   logic a32;
   a32 = (a[63:32] == 32'h0);
   push_beat({id, 8'h00, 8'hff, (a32 ? 8'h40 : 8'h60), 14'h0, 10'(2 * WR_BEATS)}, 1'b0, 1'b0);
   if (a32)
   begin
      push_beat({swap32(wr_words[0][31:0]), a[31:0]}, 1'b0, 1'b0); // address plus dword 0
      for (int k = 1; k < WR_BEATS; k++)
         push_beat({swap32(wr_words[k][31:0]), swap32(wr_words[k-1][63:32])}, 1'b0, 1'b0);
      push_beat({32'h0, swap32(wr_words[WR_BEATS-1][63:32])}, 1'b1, 1'b1);
   end
   else
   begin
      push_beat({a[31:0], a[63:32]}, 1'b0, 1'b0);
      for (int k = 0; k < WR_BEATS; k++)
         push_beat({swap32(wr_words[k][63:32]), swap32(wr_words[k][31:0])}, 1'b0,
                   k == WR_BEATS - 1);
   end
endfunction

`endif

// File: tests/pcie_tx_tb.sv
`default_nettype none

module pcie_tx_tb import pcie_tx_pkg::*; ();

   localparam int WR_BEATS  = 16;
   localparam int RD_LEN_DW = 128;
   localparam int N_REQ     = 13;
   localparam int TIMEOUT   = N_REQ * (WR_BEATS + 2) * 20; // cycles

   logic        clock;
   logic        reset;
   logic [15:0] pcie_id;
   logic        rc_done;
   logic [31:0] rc_dw2;
   logic [63:0] rc_data;
   logic        rr_valid;
   logic [63:0] rr_addr;
   logic [7:0]  rr_tag;
   logic        rr_ready;
   logic        wr_valid;
   logic [63:0] wr_addr;
   logic [63:0] wr_data;
   logic        wr_ready;
   logic        tx_tready;
   logic [63:0] tx_tdata;
   logic        tx_1dw;
   logic        tx_tlast;
   logic        tx_tvalid;

   tx_beat_t    exp_q[$];
   logic [63:0] wr_words [WR_BEATS];
   logic [31:0] lfsr;      // back-pressure bits
   logic [31:0] data_lfsr; // write payload bits
   logic        rdy_random;
   logic        rr_taken;
   int          wr_ptr;
   int          rr_cnt;
   int          wr_cnt;
   int          checks;
   int          errors;

   `include "tlp_model.svh"

   pcie_tx #(.WR_BEATS(WR_BEATS), .RD_LEN_DW(RD_LEN_DW)) i_pcie_tx (.*);

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [63:0] data_bits();
      logic [63:0] v;
      for (int i = 0; i < 64; i++)
      begin
         data_lfsr = lfsr_next(data_lfsr);
         v[i] = data_lfsr[0];
      end
      return v;
   endfunction

   task automatic start_cpl(input logic [31:0] dw2, input logic [63:0] d);
      rc_dw2  = dw2;
      rc_data = d;
      rc_done = 1'b1;
      model_cpl(pcie_id, dw2, d);
      @(negedge clock);
      rc_done = 1'b0;
   endtask

   task automatic start_read(input logic [63:0] a, input logic [7:0] tag);
      rr_addr  = a;
      rr_tag   = tag;
      rr_taken = 1'b0;
      rr_valid = 1'b1;
      model_read(pcie_id, a, tag);
   endtask

   task automatic start_write(input logic [63:0] a);
      for (int k = 0; k < WR_BEATS; k++)
         wr_words[k] = data_bits();
      wr_addr  = a;
      wr_ptr   = 0;
      wr_valid = 1'b1;
      model_write(pcie_id, a);
   endtask

   task automatic drain();
      while (exp_q.size() != 0)
         @(negedge clock);
      repeat (3) @(negedge clock);
      assert (!tx_tvalid)
      else
      begin
         errors++;
         $display("tx_tvalid still high after the packet ended at time %0t", $time);
      end
   endtask

   task automatic run_set();
      start_cpl(32'h0a0b_0c0d, 64'h1122_3344_5566_7788);
      drain();
      start_read(64'h0000_0000_1234_5678, 8'h21);
      drain();
      start_read(64'h0000_0001_89ab_cdec, 8'h22);
      drain();
      start_write(64'h0000_0000_2000_0040);
      drain();
      start_write(64'h0000_0003_4000_0080);
      drain();
   endtask

   initial
   begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   // inputs change only on the falling edge
   always @(negedge clock)
   begin
      if (rdy_random)
      begin
         lfsr = lfsr_next(lfsr);
         tx_tready = lfsr[0];
      end
      else
         tx_tready = 1'b1;
      wr_data = (wr_ptr == 0) ? 64'h0 : wr_words[wr_ptr-1];
      if (rr_taken)
         rr_valid = 1'b0;
      if (wr_ptr > 0)
         wr_valid = 1'b0; // header already taken
   end

   always @(posedge clock)
   begin
      tx_beat_t e;
      if (!reset)
      begin
         if (rr_ready)
         begin
            rr_cnt++;
            rr_taken = 1'b1;
         end
         if (wr_ready)
         begin
            wr_cnt++;
            wr_ptr++;
         end
         if (tx_tvalid && tx_tready)
         begin
            assert (exp_q.size() != 0)
            else
            begin
               errors++;
               $display("unexpected beat at time %0t with no packet pending", $time);
            end
            if (exp_q.size() != 0)
            begin
               e = exp_q.pop_front();
               checks++;
               assert (tx_tdata == e.data)
               else
               begin
                  errors++;
                  $display("Fail %0t tx_tdata %h expected %h", $time, tx_tdata, e.data);
               end
               assert (tx_1dw == e.one_dw)
               else
               begin
                  errors++;
                  $display("Fail %0t tx_1dw %b expected %b", $time, tx_1dw, e.one_dw);
               end
               assert (tx_tlast == e.last)
               else
               begin
                  errors++;
                  $display("Fail %0t tx_tlast %b expected %b", $time, tx_tlast, e.last);
               end
            end
         end
      end
   end

   initial
   begin
      repeat (TIMEOUT) @(posedge clock);
      $display("timeout after %0d cycles, %0d beats never arrived", TIMEOUT, exp_q.size());
      $display("sim failed");
      $finish;
   end

   initial
   begin
      reset      = 1'b1;
      pcie_id    = 16'h0100;
      rc_done    = 1'b0;
      rc_dw2     = '0;
      rc_data    = '0;
      rr_valid   = 1'b0;
      rr_addr    = '0;
      rr_tag     = '0;
      wr_valid   = 1'b0;
      wr_addr    = '0;
      wr_data    = '0;
      tx_tready  = 1'b1;
      lfsr       = 32'h264d;
      data_lfsr  = 32'h264d;
      rdy_random = 1'b0;
      rr_taken   = 1'b0;
      wr_ptr     = 0;
      rr_cnt     = 0;
      wr_cnt     = 0;
      checks     = 0;
      errors     = 0;
      repeat (5) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      repeat (8) @(negedge clock); // idle with nothing expected out
      assert (!tx_tvalid && !rr_ready && !wr_ready)
      else
      begin
         errors++;
         $display("outputs active after reset with no request");
      end
      run_set();
      rdy_random = 1'b1;
      run_set();
      // completion pending first and then read and write together
      start_cpl(32'h5a5a_0001, 64'hdead_beef_cafe_f00d);
      start_read(64'h0000_0000_0000_1000, 8'h33);
      start_write(64'h0000_0000_0000_2000);
      drain();
      assert (rr_cnt == 5 && wr_cnt == 5 * WR_BEATS)
      else
      begin
         errors++;
         $display("wrong handshake count, rr_ready %0d times, wr_ready %0d times",
                  rr_cnt, wr_cnt);
      end
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire
